//--- project.f
+incdir+hdl
hdl/datapathPkg.sv
hdl/registerFile.sv
hdl/specialRegs.sv
hdl/busMux.sv
hdl/aluUnit.sv
hdl/datapath.sv
dv/datapath_chk.sv
dv/datapathTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module datapathTb -f project.f
./obj_dir/VdatapathTb > sim.log 2>&1 || true
cat sim.log
if grep -qx "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- dv/datapathTb.sv
`include "datapath_params.svh"

module datapathTb
  import datapathPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 2000;  // Tests take about 300 cycles

  logic       Clock = 1'b0;
  logic       arstN;
  regEnable_t enable;
  busSel_t    busSelect;
  aluOp_t     aluOp;
  logic       mdrRead;
  word_t      memDataIn;
  word_t      inPort;
  word_t      busMuxOut;
  word_t      memAddr;
  integer     seed = 94;
  int         errors = 0;
  int         testErrors = 0;
  int         tests = 0;
  int         cycles = 0;

  datapath i_dut (.*);

  always #10 Clock = ~Clock;

  always @(posedge Clock) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic regEnable_t enableBit(int n);
    return regEnable_t'(1) << n;
  endfunction

  // Reference ALU, Y is a and the bus is b
  function automatic dword_t expectedAlu(aluOp_t op, word_t a, word_t b);
    int    sh;
    word_t w;
    sh = int'(b[4:0]);
    case (op)
      opAdd:   w = a + b;
      opSub:   w = a - b;
      opAnd:   w = a & b;
      opOr:    w = a | b;
      opShr:   w = a >> sh;
      opShl:   w = a << sh;
      opRor:   w = (a >> sh) | (a << (32 - sh));
      opRol:   w = (a << sh) | (a >> (32 - sh));
      opNeg:   w = ~b + word_t'(1);
      opNot:   w = ~b;
      opInc:   w = b + word_t'(1);
      opMul:   return longint'($signed(a)) * longint'($signed(b));
      default: w = b;
    endcase
    return {32'b0, w};
  endfunction

  task automatic checkWord(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
      testErrors++;
    end
  endtask

  task automatic checkDword(string name, dword_t exp, dword_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
      testErrors++;
    end
  endtask

  task automatic finishTest(string name);
    tests++;
    $display("%s: %s", name, (testErrors == 0) ? "ok" : "FAILED");
    testErrors = 0;
  endtask

  // One control cycle, loads happen at the following rising edge
  task automatic drive(regEnable_t en, int sel, aluOp_t op, logic rd, word_t mem);
    @(negedge Clock);
    enable    = en;
    busSelect = busSel_t'(sel);
    aluOp     = op;
    mdrRead   = rd;
    memDataIn = mem;
  endtask

  task automatic readBus(int sel, output word_t v);
    drive('0, sel, opPass, 1'b0, '0);
    #5 v = busMuxOut;
  endtask

  task automatic readPair(int hiSel, int loSel, output dword_t d);
    word_t hi;
    word_t lo;
    readBus(hiSel, hi);
    readBus(loSel, lo);
    d = {hi, lo};
  endtask

  // Memory word into MDR, then over the bus into the destination
  task automatic loadReg(int dest, word_t val);
    drive(enableBit(`EN_MDR), 0, opPass, 1'b1, val);
    drive(enableBit(dest), `SEL_MDR, opPass, 1'b0, '0);
  endtask

  task automatic aluStep(int ra, int rb, aluOp_t op);
    drive(enableBit(`EN_Y), ra, opPass, 1'b0, '0);
    drive(enableBit(`EN_Z), rb, op, 1'b0, '0);
  endtask

  task automatic resetState();
    word_t v;
    for (int s = 0; s < 32; s++) begin
      readBus(s, v);
      checkWord($sformatf("reset sel %0d", s), '0, v);
    end
    finishTest("resetState");
  endtask

  task automatic memoryLoad();
    word_t a;
    word_t b;
    word_t v;
    a = $random(seed);
    b = $random(seed);
    loadReg(6, a);
    loadReg(7, b);
    readBus(6, v);
    checkWord("R6 from MDR", a, v);
    readBus(7, v);
    checkWord("R7 from MDR", b, v);
    drive(enableBit(`EN_MDR), 6, opPass, 1'b0, ~a);  // memDataIn must be ignored
    readBus(`SEL_MDR, v);
    checkWord("MDR from bus", a, v);
    finishTest("memoryLoad");
  endtask

  task automatic aluOps();
    aluOp_t ops [12] = '{opAdd, opSub, opAnd, opOr, opShr, opShl, opRor, opRol,
                         opNeg, opNot, opInc, opPass};
    word_t  a;
    word_t  b;
    dword_t z;
    foreach (ops[i]) begin
      a = $random(seed);
      b = $random(seed);
      loadReg(1, a);
      loadReg(2, b);
      aluStep(1, 2, ops[i]);
      readPair(`SEL_ZHIGH, `SEL_ZLOW, z);
      checkDword(ops[i].name(), expectedAlu(ops[i], a, b), z);
    end
    finishTest("aluOps");
  endtask

  task automatic multiply();
    word_t  mulA [5] = '{32'h0, 32'hFFFF_FFF9, 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
    word_t  mulB [5] = '{32'h0, 32'h0001_E240, 32'h8000_0000, 32'h8000_0000, 32'hFFFF_FFFF};
    dword_t z;
    mulA[0] = $random(seed);  // First pair is random
    mulB[0] = $random(seed);
    foreach (mulA[i]) begin
      loadReg(3, mulA[i]);
      loadReg(4, mulB[i]);
      aluStep(3, 4, opMul);
      readPair(`SEL_ZHIGH, `SEL_ZLOW, z);
      checkDword($sformatf("mul Z %0d", i), expectedAlu(opMul, mulA[i], mulB[i]), z);
      drive(enableBit(`EN_HI), `SEL_ZHIGH, opPass, 1'b0, '0);
      drive(enableBit(`EN_LO), `SEL_ZLOW, opPass, 1'b0, '0);
      readPair(`SEL_HI, `SEL_LO, z);
      checkDword($sformatf("mul HI LO %0d", i), expectedAlu(opMul, mulA[i], mulB[i]), z);
    end
    finishTest("multiply");
  endtask

  task automatic pcIncrement();
    word_t start;
    word_t v;
    start = $random(seed);
    loadReg(`EN_PC, start);
    drive(enableBit(`EN_MAR), `SEL_PC, opPass, 1'b0, '0);
    drive(enableBit(`EN_Z), `SEL_PC, opInc, 1'b0, '0);
    drive(enableBit(`EN_PC), `SEL_ZLOW, opPass, 1'b0, '0);
    readBus(`SEL_ZLOW, v);  // Z stays put while its load bit is low
    checkWord("Zlow after PC load", start + word_t'(1), v);
    readBus(`SEL_PC, v);
    checkWord("PC plus one", start + word_t'(1), v);
    checkWord("memAddr", start, memAddr);
    finishTest("pcIncrement");
  endtask

  task automatic inputAndIr();
    word_t inVal;
    word_t irVal;
    word_t v;
    inVal = $random(seed);
    irVal = $random(seed);
    drive(enableBit(`EN_INPORT), 0, opPass, 1'b0, '0);
    inPort = inVal;
    readBus(`SEL_INPORT, v);
    checkWord("input latch", inVal, v);
    loadReg(`EN_IR, irVal);
    readBus(`SEL_IR, v);
    checkWord("IR", irVal, v);
    finishTest("inputAndIr");
  endtask

  initial begin
    arstN     = 1'b0;
    enable    = '0;
    busSelect = '0;
    aluOp     = opPass;
    mdrRead   = 1'b0;
    memDataIn = '0;
    inPort    = '0;
    repeat (16) @(posedge Clock);
    @(negedge Clock);
    arstN = 1'b1;
    resetState();
    memoryLoad();
    aluOps();
    multiply();
    pcIncrement();
    inputAndIr();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- dv/datapath_chk.sv
`include "datapath_params.svh"

module datapathChk
  import datapathPkg::*;
(
  input logic       Clock,
  input logic       arstN,
  input regEnable_t enable,
  input busSel_t    busSelect,
  input word_t      busMuxOut,
  input word_t      memAddr
);
  timeunit 1ns;
  timeprecision 1ps;

  // Everything reads zero right after reset
  assert property (@(posedge Clock) $rose(arstN) |-> (memAddr == '0 && busMuxOut == '0))
    else $error("memAddr or bus not zero after reset release");

  // Zlow holds while Z is not loaded
  assert property (@(posedge Clock) disable iff (!arstN)
    (busSelect == busSel_t'(`SEL_ZLOW) && $past(busSelect) == busSel_t'(`SEL_ZLOW)
     && !$past(enable[`EN_Z])) |-> busMuxOut == $past(busMuxOut))
    else $error("Zlow changed without a Z load");

endmodule

bind datapath datapathChk i_chk (.*);

//--- hdl/datapath.sv
module datapath
  import datapathPkg::*;
(
  input  logic       Clock,
  input  logic       arstN,
  input  regEnable_t enable,
  input  busSel_t    busSelect,
  input  aluOp_t     aluOp,
  input  logic       mdrRead,
  input  word_t      memDataIn,
  input  word_t      inPort,
  output word_t      busMuxOut,
  output word_t      memAddr
);

  gprBank_t     gpr;
  specialBank_t special;
  word_t        bus;
  dword_t       aluResult;

  registerFile i_regFile (
    .Clock  (Clock),
    .arstN  (arstN),
    .enable (enable),
    .bus    (bus),
    .gpr    (gpr)
  );

  specialRegs i_specialRegs (
    .Clock     (Clock),
    .arstN     (arstN),
    .enable    (enable),
    .bus       (bus),
    .aluResult (aluResult),
    .mdrRead   (mdrRead),
    .memDataIn (memDataIn),
    .inPort    (inPort),
    .special   (special)
  );

  // Shared bus, one source per cycle
  busMux i_busMux (
    .busSel  (busSelect),
    .gpr     (gpr),
    .special (special),
    .bus     (bus)
  );

  // Y is always operand a, the bus operand b
  aluUnit i_alu (
    .aluOp  (aluOp),
    .a      (special.y),
    .b      (bus),
    .result (aluResult)
  );

  assign busMuxOut = bus;
  assign memAddr   = special.mar;

endmodule

//--- hdl/aluUnit.sv
`include "datapath_params.svh"

module aluUnit
  import datapathPkg::*;
(
  input  aluOp_t aluOp,
  input  word_t  a,
  input  word_t  b,
  output dword_t result
);

  shiftAmt_t shamt;
  dword_t    rotSource;
  dword_t    rorWide;
  dword_t    rolWide;
  dword_t    product;
  word_t     wordRes;

  assign shamt = b[4:0];  // Only the low five bits count

  // Doubling the word turns a rotate into a plain shift
  assign rotSource = {a, a};
  assign rorWide   = rotSource >> shamt;
  assign rolWide   = rotSource << shamt;

  // Sign extend both operands so the low 64 bits are the signed product
  assign product = {{`WORD_W{a[`WORD_W-1]}}, a} * {{`WORD_W{b[`WORD_W-1]}}, b};

  always_comb begin
    case (aluOp)
      opAdd:   wordRes = a + b;
      opSub:   wordRes = a - b;
      opAnd:   wordRes = a & b;
      opOr:    wordRes = a | b;
      opShr:   wordRes = a >> shamt;  // Logical, zero fill
      opShl:   wordRes = a << shamt;
      opRor:   wordRes = rorWide[`WORD_W-1:0];
      opRol:   wordRes = rolWide[2*`WORD_W-1:`WORD_W];
      opNeg:   wordRes = -b;
      opNot:   wordRes = ~b;
      opInc:   wordRes = b + word_t'(1);
      opPass:  wordRes = b;
      default: wordRes = '0;
    endcase
  end

  // Multiply fills both halves, everything else lands in Zlow
  always_comb begin
    if (aluOp == opMul) begin
      result = product;
    end else begin
      result = {{`WORD_W{1'b0}}, wordRes};
    end
  end

endmodule

//--- hdl/busMux.sv
`include "datapath_params.svh"

module busMux
  import datapathPkg::*;
(
  input  busSel_t      busSel,
  input  gprBank_t     gpr,
  input  specialBank_t special,
  output word_t        bus
);

  // Upper bit clear means one of the sixteen general registers
  logic isGpr;

  assign isGpr = (busSel < busSel_t'(`NUM_GPR));

  always_comb begin
    bus = '0;  // Unused codes put zero on the bus
    if (isGpr) begin
      bus = gpr.r[busSel[3:0]];
    end else begin
      case (busSel)
        busSel_t'(`SEL_HI):     bus = gpr.hi;
        busSel_t'(`SEL_LO):     bus = gpr.lo;
        busSel_t'(`SEL_ZHIGH):  bus = special.zHigh;
        busSel_t'(`SEL_ZLOW):   bus = special.zLow;
        busSel_t'(`SEL_PC):     bus = special.pc;
        busSel_t'(`SEL_MDR):    bus = special.mdr;
        busSel_t'(`SEL_INPORT): bus = special.inPortReg;
        busSel_t'(`SEL_IR):     bus = special.ir;
        default:                bus = '0;
      endcase
    end
  end

endmodule

//--- hdl/specialRegs.sv
`include "datapath_params.svh"

module specialRegs
  import datapathPkg::*;
(
  input  logic         Clock,
  input  logic         arstN,
  input  regEnable_t   enable,
  input  word_t        bus,
  input  dword_t       aluResult,
  input  logic         mdrRead,
  input  word_t        memDataIn,
  input  word_t        inPort,
  output specialBank_t special
);

  word_t mdrNext;

  // MDR source is memory data on a read, otherwise the bus
  assign mdrNext = mdrRead ? memDataIn : bus;

  // Program counter, advanced through Z by the sequencer
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      special.pc <= '0;
    end else if (enable[`EN_PC]) begin
      special.pc <= bus;
    end
  end

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      special.ir <= '0;
    end else if (enable[`EN_IR]) begin
      special.ir <= bus;  // Instruction word, only stored and read back
    end
  end

  // Y holds the first ALU operand
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      special.y <= '0;
    end else if (enable[`EN_Y]) begin
      special.y <= bus;
    end
  end

  // Both Z halves load together from the ALU
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      special.zHigh <= '0;
      special.zLow  <= '0;
    end else if (enable[`EN_Z]) begin
      special.zHigh <= aluResult[2*`WORD_W-1:`WORD_W];
      special.zLow  <= aluResult[`WORD_W-1:0];
    end
  end

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      special.mdr <= '0;
    end else if (enable[`EN_MDR]) begin
      special.mdr <= mdrNext;
    end
  end

  // MAR drives the memory address port directly
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      special.mar <= '0;
    end else if (enable[`EN_MAR]) begin
      special.mar <= bus;
    end
  end

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      special.inPortReg <= '0;
    end else if (enable[`EN_INPORT]) begin
      special.inPortReg <= inPort;  // Latch the external input
    end
  end

endmodule

//--- hdl/registerFile.sv
`include "datapath_params.svh"

module registerFile
  import datapathPkg::*;
(
  input  logic       Clock,
  input  logic       arstN,
  input  regEnable_t enable,
  input  word_t      bus,
  output gprBank_t   gpr
);

  // R0 to R15, each with its own load bit
  genvar g;
  generate
    for (g = 0; g < `NUM_GPR; g++) begin : gprLoad
      always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
          gpr.r[g] <= '0;
        end else if (enable[g]) begin
          gpr.r[g] <= bus;
        end
      end
    end
  endgenerate

  // HI takes the upper product word when moved over the bus
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      gpr.hi <= '0;
    end else if (enable[`EN_HI]) begin
      gpr.hi <= bus;
    end
  end

  // LO takes the lower product word
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      gpr.lo <= '0;
    end else if (enable[`EN_LO]) begin
      gpr.lo <= bus;
    end
  end

endmodule

//--- hdl/datapathPkg.sv
`include "datapath_params.svh"

package datapathPkg;

  typedef logic [`WORD_W-1:0]   word_t;       // One data word
  typedef logic [2*`WORD_W-1:0] dword_t;      // Full ALU result, Zhigh:Zlow
  typedef logic [`SEL_W-1:0]    busSel_t;     // Encoded bus source
  typedef logic [`WORD_W-1:0]   regEnable_t;  // One load bit per destination
  typedef logic [4:0]           shiftAmt_t;   // Shift and rotate distance

  // ALU operation codes as driven by the sequencer
  typedef enum logic [3:0] {
    opPass = 4'd0,
    opAdd  = 4'd3,
    opSub  = 4'd4,
    opAnd  = 4'd5,
    opOr   = 4'd6,
    opShr  = 4'd7,
    opShl  = 4'd8,
    opRor  = 4'd9,
    opRol  = 4'd10,
    opMul  = 4'd12,
    opNeg  = 4'd13,
    opNot  = 4'd14,
    opInc  = 4'd15
  } aluOp_t;

  // General register bank plus the multiply result pair
  typedef struct packed {
    word_t [`NUM_GPR-1:0] r;
    word_t                hi;
    word_t                lo;
  } gprBank_t;

  // Special purpose registers of the datapath
  typedef struct packed {
    word_t pc;
    word_t ir;
    word_t y;
    word_t zHigh;
    word_t zLow;
    word_t mdr;
    word_t mar;
    word_t inPortReg;
  } specialBank_t;

endpackage

//--- hdl/datapath_params.svh
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// Widths
`define WORD_W      32
`define NUM_GPR     16
`define SEL_W       5

// Bus source codes, 0..15 pick R0..R15
`define SEL_HI      16
`define SEL_LO      17
`define SEL_ZHIGH   18
`define SEL_ZLOW    19
`define SEL_PC      20
`define SEL_MDR     21
`define SEL_INPORT  22
`define SEL_IR      23

// Load enable bit positions, bits 0..15 load R0..R15
`define EN_HI       16
`define EN_LO       17
`define EN_PC       20
`define EN_MDR      21
`define EN_INPORT   22
`define EN_IR       23
`define EN_Z        24
`define EN_MAR      25
`define EN_Y        27

`endif
